// ==== Bender.yml ====
package:
  name: alpha_subsystem

sources:
  - include_dirs:
      - .
    files:
      - alpha_pkg.sv
      - alpha_seq_if.sv
      - button_debounce.sv
      - startup_sequencer.sv
      - alpha_control.sv
      - alpha_readout.sv
      - alpha_subsystem.sv
  - target: test
    include_dirs:
      - .
    files:
      - alpha_props.sv
      - alpha_tb.sv

// ==== alpha_control.sv ====
`include "alpha_defines.svh"
`timescale 1ns/1ns
`default_nettype none

module alpha_control (
	input  logic sysclk,
	input  logic reset,
	alpha_seq_if.control seq,
	input  alpha_pkg::bias_t cmp_bias,
	input  alpha_pkg::bias_t isel,
	input  alpha_pkg::bias_t sb_bias,
	input  alpha_pkg::bias_t db_bias,
	input  logic tok_a_out,
	output logic dreset,
	output logic sync,
	output logic sin,
	output logic sclk,
	output logic pclk,
	output logic trigin,
	output logic tok_a_in
);

	alpha_pkg::ctrl_state_t state;
	logic [8:0] cycle_cnt;
	logic [3:0] bit_cnt;
	logic [1:0] reg_idx;
	logic [15:0] shift_word;
	alpha_pkg::bias_t bias_q [0:3];
	alpha_pkg::bias_addr_t next_addr;

	assign next_addr = {2'b00, reg_idx} + 4'd1;

	// busy already in the strobe cycle, so the sequencer holds its count
	assign seq.ctrl_busy = (state != alpha_pkg::IDLE) || seq.do_dreset || seq.do_sync ||
		seq.do_load || seq.do_readout;

	// pins decoded from state
	assign dreset = (state == alpha_pkg::DRESET);
	assign sync = (state == alpha_pkg::SYNC);
	assign sclk = (state == alpha_pkg::SHIFT_HIGH);
	assign pclk = (state == alpha_pkg::LATCH);
	assign sin = shift_word[15] && (state == alpha_pkg::SHIFT_LOW || state == alpha_pkg::SHIFT_HIGH);
	assign trigin = (state == alpha_pkg::TRIG_WAIT) && (cycle_cnt == '0);
	assign tok_a_in = (state == alpha_pkg::TOKEN);

	// --------------------
	// bias capture and shift word, address over value, msb first
	always_ff @(posedge sysclk) begin
		if (state == alpha_pkg::IDLE && seq.do_load) begin
			bias_q[0] <= cmp_bias;
			bias_q[1] <= isel;
			bias_q[2] <= sb_bias;
			bias_q[3] <= db_bias;
			shift_word <= {4'h0, cmp_bias};
		end else if (state == alpha_pkg::SHIFT_HIGH) begin
			shift_word <= {shift_word[14:0], 1'b0};
		end else if (state == alpha_pkg::LATCH) begin
			shift_word <= {next_addr, bias_q[next_addr[1:0]]};
		end
	end

	// --------------------
	// step fsm
	always_ff @(posedge sysclk) begin
		if (reset) begin
			state <= alpha_pkg::IDLE;
			cycle_cnt <= '0;
			bit_cnt <= '0;
			reg_idx <= '0;
		end else begin
			case (state)
				alpha_pkg::IDLE: begin
					cycle_cnt <= '0;
					bit_cnt <= '0;
					reg_idx <= '0;
					if (seq.do_dreset) begin
						state <= alpha_pkg::DRESET;
					end else if (seq.do_sync) begin
						state <= alpha_pkg::SYNC;
					end else if (seq.do_load) begin
						state <= alpha_pkg::SHIFT_LOW;
					end else if (seq.do_readout) begin
						state <= alpha_pkg::TRIG_WAIT;
					end
				end
				alpha_pkg::DRESET: begin
					if (cycle_cnt == `ALPHA_DRESET_CYCLES - 1) begin
						state <= alpha_pkg::IDLE;
					end
					cycle_cnt <= cycle_cnt + 9'd1;
				end
				alpha_pkg::SYNC: begin
					if (cycle_cnt == `ALPHA_SYNC_CYCLES - 1) begin
						state <= alpha_pkg::IDLE;
					end
					cycle_cnt <= cycle_cnt + 9'd1;
				end
				alpha_pkg::SHIFT_LOW: begin
					state <= alpha_pkg::SHIFT_HIGH;
				end
				alpha_pkg::SHIFT_HIGH: begin
					if (bit_cnt == 4'd15) begin
						state <= alpha_pkg::LATCH;
					end else begin
						bit_cnt <= bit_cnt + 4'd1;
						state <= alpha_pkg::SHIFT_LOW;
					end
				end
				alpha_pkg::LATCH: begin
					bit_cnt <= '0;
					if (reg_idx == 2'd3) begin
						state <= alpha_pkg::IDLE;
					end else begin
						reg_idx <= reg_idx + 2'd1;
						state <= alpha_pkg::SHIFT_LOW;
					end
				end
				alpha_pkg::TRIG_WAIT: begin
					if (cycle_cnt == `ALPHA_TOKEN_DELAY - 1) begin
						cycle_cnt <= '0;
						state <= alpha_pkg::TOKEN;
					end else begin
						cycle_cnt <= cycle_cnt + 9'd1;
					end
				end
				alpha_pkg::TOKEN: begin
					// token back, or give up
					if (tok_a_out || cycle_cnt == `ALPHA_TOKEN_TIMEOUT - 1) begin
						state <= alpha_pkg::IDLE;
					end
					cycle_cnt <= cycle_cnt + 9'd1;
				end
				default: begin
					state <= alpha_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== alpha_defines.svh ====
`ifndef ALPHA_DEFINES_SVH
`define ALPHA_DEFINES_SVH

// startup sequencer
// idle time before each step
`define ALPHA_SEQ_WAIT_CYCLES 64

// --------------------
// pulse lengths on the chip pins
`define ALPHA_DRESET_CYCLES 16
`define ALPHA_SYNC_CYCLES 4

// trigger to token spacing, and how long to wait for it to come back
`define ALPHA_TOKEN_DELAY 8
`define ALPHA_TOKEN_TIMEOUT 256

// button must be this stable before the debounced level moves
`define ALPHA_DEBOUNCE_CYCLES 32

// --------------------
// serial readout framing
`define ALPHA_HEADER_PATTERN 8'hA5
`define ALPHA_HEADER_BITS 8
`define ALPHA_WORD_BITS 16

`endif

// ==== alpha_pkg.sv ====
`include "alpha_defines.svh"
`default_nettype none

package alpha_pkg;

	// bias dac value and its register address
	typedef logic [11:0] bias_t;
	typedef logic [3:0] bias_addr_t;

	// readout payload
	typedef logic [3:0] nybble_t;
	typedef logic [`ALPHA_WORD_BITS-1:0] data_word_t;

	// --------------------
	// startup steps, in order
	typedef enum logic [1:0] {
		WAIT_DRESET,
		WAIT_SYNC,
		WAIT_LOAD,
		ARMED
	} seq_state_t;

	typedef enum logic [2:0] {
		IDLE,
		DRESET,
		SYNC,
		SHIFT_LOW,
		SHIFT_HIGH,
		LATCH,
		TRIG_WAIT,
		TOKEN
	} ctrl_state_t;

	typedef enum logic {
		HUNT,
		DATA
	} rd_state_t;

endpackage

`default_nettype wire

// ==== alpha_props.sv ====
`include "alpha_defines.svh"
`timescale 1ns/1ns
`default_nettype none

module alpha_props (
	input logic sysclk,
	input logic reset,
	input logic dreset,
	input logic sclk,
	input logic pclk,
	input logic trigin,
	input logic tok_a_in,
	input logic [3:0] step_done
);

	// cycles since the load strobe, saturating
	logic [7:0] since_load;

	always_ff @(posedge sysclk) begin
		if (reset) begin
			since_load <= '0;
		end else if (step_done[2] && since_load != 8'hff) begin
			since_load <= since_load + 8'd1;
		end
	end

	dreset_len_a: assert property (@(posedge sysclk) disable iff (reset)
		$rose(dreset) |-> dreset [*`ALPHA_DRESET_CYCLES] ##1 !dreset)
		else $error("dreset pulse is not %0d cycles long", `ALPHA_DRESET_CYCLES);

	// latch sits in the low phase right after the last bit
	pclk_sclk_a: assert property (@(posedge sysclk) disable iff (reset)
		pclk |-> (!sclk && $past(sclk)))
		else $error("pclk not in the low phase after the last sclk");

	// whole load is 4 x 33 cycles
	sclk_load_a: assert property (@(posedge sysclk) disable iff (reset)
		sclk |-> (step_done[2] && since_load <= 8'd132))
		else $error("sclk active outside the bias load");

	// token stays low through the trigger and its delay
	trig_tok_a: assert property (@(posedge sysclk) disable iff (reset)
		trigin |-> !tok_a_in [*`ALPHA_TOKEN_DELAY] ##1 tok_a_in)
		else $error("tok_a_in overlaps trigin or misses its delay");

endmodule

bind alpha_subsystem alpha_props alpha_props_i (
	.sysclk    (sysclk),
	.reset     (reset),
	.dreset    (dreset),
	.sclk      (sclk),
	.pclk      (pclk),
	.trigin    (trigin),
	.tok_a_in  (tok_a_in),
	.step_done (step_done)
);

`default_nettype wire

// ==== alpha_readout.sv ====
`include "alpha_defines.svh"
`timescale 1ns/1ns
`default_nettype none

module alpha_readout (
	input  logic sysclk,
	input  logic reset,
	input  logic data_a,
	output logic header,
	output logic msn,
	output logic word_valid,
	output alpha_pkg::nybble_t nybble,
	output alpha_pkg::data_word_t data_word
);

	alpha_pkg::rd_state_t state;
	logic [`ALPHA_HEADER_BITS-2:0] hdr_sr;
	logic [`ALPHA_WORD_BITS-2:0] word_sr;
	logic [3:0] bit_cnt;
	logic match;

	// window is the stored bits plus the one arriving now
	assign match = ({hdr_sr, data_a} == `ALPHA_HEADER_PATTERN);

	// --------------------
	// payload shift, no reset
	always_ff @(posedge sysclk) begin
		word_sr <= {word_sr[`ALPHA_WORD_BITS-3:0], data_a};
	end

	always_ff @(posedge sysclk) begin
		header <= 1'b0;
		msn <= 1'b0;
		word_valid <= 1'b0;
		if (reset) begin
			state <= alpha_pkg::HUNT;
			hdr_sr <= '0;
			bit_cnt <= '0;
			nybble <= '0;
			data_word <= '0;
		end else begin
			case (state)
				alpha_pkg::HUNT: begin
					hdr_sr <= {hdr_sr[`ALPHA_HEADER_BITS-3:0], data_a};
					bit_cnt <= '0;
					if (match) begin
						header <= 1'b1;
						state <= alpha_pkg::DATA;
					end
				end
				alpha_pkg::DATA: begin
					// no header search inside a word
					bit_cnt <= bit_cnt + 4'd1;
					if (bit_cnt[1:0] == 2'd3) begin
						nybble <= {word_sr[2:0], data_a};
						msn <= (bit_cnt[3:2] == 2'd0);
					end
					if (bit_cnt == 4'd15) begin
						word_valid <= 1'b1;
						data_word <= {word_sr, data_a};
						// start the next hunt from a clean window
						hdr_sr <= '0;
						state <= alpha_pkg::HUNT;
					end
				end
				default: begin
					state <= alpha_pkg::HUNT;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== alpha_seq_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface alpha_seq_if;

	// one-cycle step requests
	logic do_dreset;
	logic do_sync;
	logic do_load;
	logic do_readout;

	// control block still working on the last request
	logic ctrl_busy;

	modport sequencer (
		output do_dreset,
		output do_sync,
		output do_load,
		output do_readout,
		input  ctrl_busy
	);

	modport control (
		input  do_dreset,
		input  do_sync,
		input  do_load,
		input  do_readout,
		output ctrl_busy
	);

endinterface

`default_nettype wire

// ==== alpha_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module alpha_subsystem (
	input  logic sysclk,
	input  logic reset,
	input  logic button,
	input  alpha_pkg::bias_t cmp_bias,
	input  alpha_pkg::bias_t isel,
	input  alpha_pkg::bias_t sb_bias,
	input  alpha_pkg::bias_t db_bias,
	input  logic tok_a_out,
	input  logic data_a,
	output logic dreset,
	output logic sync,
	output logic sin,
	output logic sclk,
	output logic pclk,
	output logic trigin,
	output logic tok_a_in,
	output logic header,
	output logic word_valid,
	output logic msn,
	output alpha_pkg::nybble_t nybble,
	output alpha_pkg::data_word_t data_word,
	output logic [3:0] step_done
);

	logic press;

	// step requests between sequencer and control
	alpha_seq_if seq_if ();

	button_debounce button_debounce_i (
		.sysclk (sysclk),
		.reset  (reset),
		.button (button),
		.press  (press)
	);

	startup_sequencer startup_sequencer_i (
		.sysclk    (sysclk),
		.reset     (reset),
		.press     (press),
		.seq       (seq_if.sequencer),
		.step_done (step_done)
	);

	alpha_control alpha_control_i (
		.sysclk    (sysclk),
		.reset     (reset),
		.seq       (seq_if.control),
		.cmp_bias  (cmp_bias),
		.isel      (isel),
		.sb_bias   (sb_bias),
		.db_bias   (db_bias),
		.tok_a_out (tok_a_out),
		.dreset    (dreset),
		.sync      (sync),
		.sin       (sin),
		.sclk      (sclk),
		.pclk      (pclk),
		.trigin    (trigin),
		.tok_a_in  (tok_a_in)
	);

	// free running, not tied to the token cycle
	alpha_readout alpha_readout_i (
		.sysclk     (sysclk),
		.reset      (reset),
		.data_a     (data_a),
		.header     (header),
		.msn        (msn),
		.word_valid (word_valid),
		.nybble     (nybble),
		.data_word  (data_word)
	);

endmodule

`default_nettype wire

// ==== alpha_tb.sv ====
`include "alpha_defines.svh"
`timescale 1ns/1ns
`default_nettype none

module alpha_tb;

	localparam int act_wait_step = 0;
	localparam int act_check_load = 1;
	localparam int act_press = 2;
	localparam int act_serial = 3;
	localparam int act_glitch = 4;
	localparam int tok_model_delay = 5;
	localparam int wait_limit = 600;

	logic sysclk;
	logic reset;
	logic button;
	alpha_pkg::bias_t cmp_bias;
	alpha_pkg::bias_t isel;
	alpha_pkg::bias_t sb_bias;
	alpha_pkg::bias_t db_bias;
	logic tok_a_out = 1'b0;
	logic data_a;
	logic dreset;
	logic sync;
	logic sin;
	logic sclk;
	logic pclk;
	logic trigin;
	logic tok_a_in;
	logic header;
	logic word_valid;
	logic msn;
	alpha_pkg::nybble_t nybble;
	alpha_pkg::data_word_t data_word;
	logic [3:0] step_done;

	alpha_pkg::bias_t bias_val [0:3];
	logic tok_model_en = 1'b1;
	int error_count = 0;

	// test table
	string row_name [$];
	int row_act [$];
	logic [31:0] row_stim [$];
	logic [31:0] row_aux [$];
	logic [31:0] row_exp [$];

	// monitor state
	int cyc = 0;
	int dreset_run = 0;
	int dreset_len = 0;
	int dreset_pulses = 0;
	int dreset_end = 0;
	int sync_run = 0;
	int sync_len = 0;
	int sync_pulses = 0;
	int sync_start = 0;
	int sclk_count = 0;
	int pclk_count = 0;
	logic [15:0] shift_acc = '0;
	logic [15:0] loaded [$];
	int trig_count = 0;
	int trig_cyc = 0;
	int tok_rise_cyc = 0;
	int tok_run = 0;
	int tok_len = 0;
	int tok_falls = 0;
	logic tok_out_at_fall = 1'b0;
	int tok_wait = 0;
	int header_count = 0;
	int word_count = 0;
	int msn_count = 0;
	alpha_pkg::nybble_t msn_nyb = '0;
	logic dreset_prev = 1'b0;
	logic sync_prev = 1'b0;
	logic sclk_prev = 1'b0;
	logic pclk_prev = 1'b0;
	logic tok_prev = 1'b0;

	alpha_subsystem dut_i (
		.sysclk    (sysclk),
		.reset     (reset),
		.button    (button),
		.cmp_bias  (cmp_bias),
		.isel      (isel),
		.sb_bias   (sb_bias),
		.db_bias   (db_bias),
		.tok_a_out (tok_a_out),
		.data_a    (data_a),
		.dreset    (dreset),
		.sync      (sync),
		.sin       (sin),
		.sclk      (sclk),
		.pclk      (pclk),
		.trigin    (trigin),
		.tok_a_in  (tok_a_in),
		.header    (header),
		.word_valid(word_valid),
		.msn       (msn),
		.nybble    (nybble),
		.data_word (data_word),
		.step_done (step_done)
	);

	initial sysclk = 1'b0;
	always #2 sysclk = ~sysclk;

	// --------------------
	// pin monitor, sampled mid-cycle
	always @(negedge sysclk) begin
		cyc++;
		if (dreset) begin
			dreset_run++;
		end else if (dreset_prev) begin
			dreset_pulses++;
			dreset_len = dreset_run;
			dreset_run = 0;
			dreset_end = cyc;
		end
		if (sync && !sync_prev) begin
			sync_start = cyc;
		end
		if (sync) begin
			sync_run++;
		end else if (sync_prev) begin
			sync_pulses++;
			sync_len = sync_run;
			sync_run = 0;
		end
		// chip shifts sin in on the rising sclk
		if (sclk && !sclk_prev) begin
			shift_acc = {shift_acc[14:0], sin};
			sclk_count++;
		end
		if (pclk && !pclk_prev) begin
			loaded.push_back(shift_acc);
			pclk_count++;
		end
		if (trigin) begin
			trig_count++;
			trig_cyc = cyc;
		end
		if (tok_a_in) begin
			if (!tok_prev) begin
				tok_rise_cyc = cyc;
				tok_run = 0;
			end
			tok_run++;
		end else if (tok_prev) begin
			tok_falls++;
			tok_len = tok_run;
			tok_out_at_fall = tok_a_out;
		end
		if (header) header_count++;
		if (word_valid) word_count++;
		if (msn) begin
			msn_count++;
			msn_nyb = nybble;
		end
		dreset_prev = dreset;
		sync_prev = sync;
		sclk_prev = sclk;
		pclk_prev = pclk;
		tok_prev = tok_a_in;
	end

	// chip side of the token ring
	always @(negedge sysclk) begin
		if (tok_a_in !== 1'b1) begin
			tok_a_out <= 1'b0;
			tok_wait <= 0;
		end else begin
			if (tok_wait == tok_model_delay - 1 && tok_model_en) tok_a_out <= 1'b1;
			tok_wait <= tok_wait + 1;
		end
	end

	// --------------------
	task automatic check_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			$display("Error %s: expected %0h, actual %0h", what, exp, act);
			error_count++;
		end
	endtask

	task automatic note_timeout(input string what);
		$display("%s", what);
		error_count++;
	endtask

	task automatic add_row(input string name, input int act, input logic [31:0] stim,
		input logic [31:0] aux, input logic [31:0] exp);
		row_name.push_back(name);
		row_act.push_back(act);
		row_stim.push_back(stim);
		row_aux.push_back(aux);
		row_exp.push_back(exp);
	endtask

	task automatic wait_step_bit(input string name, input int bit_idx, input logic [31:0] exp);
		int n;
		n = 0;
		while (step_done[bit_idx] !== 1'b1 && n < wait_limit) begin
			@(negedge sysclk);
			n++;
		end
		if (step_done[bit_idx] !== 1'b1) begin
			note_timeout($sformatf("%s: step_done bit %0d never rose", name, bit_idx));
		end
		check_value(name, exp, {28'd0, step_done});
		// load strobe just issued, so both pulses must be over already
		if (bit_idx == 2) begin
			check_value({name, " dreset pulses"}, 1, dreset_pulses);
			check_value({name, " dreset len"}, `ALPHA_DRESET_CYCLES, dreset_len);
			check_value({name, " sync pulses"}, 1, sync_pulses);
			check_value({name, " sync len"}, `ALPHA_SYNC_CYCLES, sync_len);
			check_value({name, " order"}, 1, (dreset_end <= sync_start) ? 1 : 0);
			check_value({name, " sclk before load"}, 0, sclk_count);
		end
	endtask

	task automatic check_bias_load(input string name, input logic [31:0] exp);
		int n;
		n = 0;
		do begin
			@(posedge sysclk);
			n++;
		end while (pclk_count < 4 && n < wait_limit);
		if (pclk_count < 4) note_timeout($sformatf("%s: bias load never finished", name));
		// any extra latch would show up here
		repeat (40) @(posedge sysclk);
		@(negedge sysclk);
		check_value({name, " pclk count"}, exp, pclk_count);
		for (int i = 0; i < 4; i++) begin
			if (i < loaded.size()) begin
				check_value($sformatf("%s reg %0d", name, i), {16'd0, i[3:0], bias_val[i]},
					{16'd0, loaded[i]});
			end
		end
	endtask

	task automatic press_button(input string name, input int hold, input logic model_on,
		input logic [31:0] exp);
		int trig_before;
		int fall_before;
		int n;
		trig_before = trig_count;
		fall_before = tok_falls;
		tok_model_en = model_on;
		button = 1'b0;
		repeat (hold) @(negedge sysclk);
		button = 1'b1;
		n = 0;
		do begin
			@(posedge sysclk);
			n++;
		end while (tok_falls == fall_before && n < wait_limit);
		if (tok_falls == fall_before) note_timeout($sformatf("%s: tok_a_in never dropped", name));
		@(negedge sysclk);
		check_value({name, " trigin pulses"}, 1, trig_count - trig_before);
		check_value({name, " token delay"}, `ALPHA_TOKEN_DELAY, tok_rise_cyc - trig_cyc);
		check_value({name, " token len"}, exp, tok_len);
		check_value({name, " readout done"}, 1, {31'd0, step_done[3]});
		if (model_on) check_value({name, " token back"}, 1, {31'd0, tok_out_at_fall});
		// let the release settle
		repeat (`ALPHA_DEBOUNCE_CYCLES + 8) @(negedge sysclk);
	endtask

	task automatic glitch_button(input string name, input int low_cycles, input logic [31:0] exp);
		int trig_before;
		trig_before = trig_count;
		button = 1'b0;
		repeat (low_cycles) @(negedge sysclk);
		button = 1'b1;
		repeat (2 * `ALPHA_DEBOUNCE_CYCLES) @(negedge sysclk);
		check_value({name, " trigin pulses"}, exp, trig_count - trig_before);
	endtask

	task automatic send_serial(input string name, input logic [31:0] stim,
		input logic with_header, input logic [31:0] exp);
		logic [7:0] hdr;
		logic [15:0] w;
		int hdr_before;
		int words_before;
		int msn_before;
		int n;
		hdr = `ALPHA_HEADER_PATTERN;
		w = stim[15:0];
		hdr_before = header_count;
		words_before = word_count;
		msn_before = msn_count;
		if (with_header) begin
			for (int i = `ALPHA_HEADER_BITS - 1; i >= 0; i--) begin
				data_a = hdr[i];
				@(negedge sysclk);
			end
			for (int i = `ALPHA_WORD_BITS - 1; i >= 0; i--) begin
				data_a = w[i];
				@(negedge sysclk);
				if (i % 4 == 0) begin
					check_value($sformatf("%s nybble %0d", name, 3 - i / 4), {28'd0, w[i +: 4]},
						{28'd0, nybble});
				end
			end
			data_a = 1'b0;
			n = 0;
			do begin
				@(posedge sysclk);
				n++;
			end while (word_count == words_before && n < 64);
			if (word_count == words_before) note_timeout($sformatf("%s: no word_valid", name));
			@(negedge sysclk);
			check_value({name, " data_word"}, exp, {16'd0, data_word});
			check_value({name, " headers"}, 1, header_count - hdr_before);
			check_value({name, " words"}, 1, word_count - words_before);
			check_value({name, " msn pulses"}, 1, msn_count - msn_before);
			check_value({name, " msn nybble"}, {28'd0, w[15:12]}, {28'd0, msn_nyb});
		end else begin
			for (int i = 31; i >= 0; i--) begin
				data_a = stim[i];
				@(negedge sysclk);
			end
			data_a = 1'b0;
			repeat (16) @(negedge sysclk);
			check_value({name, " headers"}, exp, header_count - hdr_before);
		end
	endtask

	// --------------------
	initial begin
		logic [31:0] rnd;
		int errs_before;
		int pass_rows;
		int fail_rows;
		rnd = $urandom(32'heef8);
		pass_rows = 0;
		fail_rows = 0;
		reset = 1'b1;
		button = 1'b1;
		data_a = 1'b0;
		for (int i = 0; i < 4; i++) begin
			rnd = $urandom;
			bias_val[i] = rnd[11:0];
		end
		cmp_bias = bias_val[0];
		isel = bias_val[1];
		sb_bias = bias_val[2];
		db_bias = bias_val[3];

		add_row("dreset_step", act_wait_step, 0, 0, 32'h1);
		add_row("sync_step", act_wait_step, 1, 0, 32'h3);
		add_row("load_step", act_wait_step, 2, 0, 32'h7);
		add_row("bias_regs", act_check_load, 0, 0, 4);
		add_row("press_token", act_press, 48, 1, tok_model_delay);
		add_row("short_glitch", act_glitch, 10, 0, 0);
		add_row("token_timeout", act_press, 48, 0, `ALPHA_TOKEN_TIMEOUT);
		rnd = $urandom;
		add_row("word_a", act_serial, {16'd0, rnd[15:0]}, 1, {16'd0, rnd[15:0]});
		rnd = $urandom;
		add_row("word_b", act_serial, {16'd0, rnd[15:0]}, 1, {16'd0, rnd[15:0]});
		// no 8-bit window of this equals the header
		add_row("noise", act_serial, 32'hf0f0_f0f0, 0, 0);

		repeat (8) @(negedge sysclk);
		reset = 1'b0;

		for (int r = 0; r < row_name.size(); r++) begin
			errs_before = error_count;
			@(negedge sysclk);
			case (row_act[r])
				act_wait_step: wait_step_bit(row_name[r], row_stim[r], row_exp[r]);
				act_check_load: check_bias_load(row_name[r], row_exp[r]);
				act_press: press_button(row_name[r], row_stim[r], row_aux[r][0], row_exp[r]);
				act_glitch: glitch_button(row_name[r], row_stim[r], row_exp[r]);
				act_serial: send_serial(row_name[r], row_stim[r], row_aux[r][0], row_exp[r]);
				default: note_timeout($sformatf("%s: unknown action", row_name[r]));
			endcase
			if (error_count == errs_before) begin
				pass_rows++;
				$display("ok    %s", row_name[r]);
			end else begin
				fail_rows++;
				$display("FAIL  %s", row_name[r]);
			end
		end

		$display("%0d tests, %0d passed, %0d failed, %0d errors", pass_rows + fail_rows,
			pass_rows, fail_rows, error_count);
		if (error_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
alpha_pkg.sv
alpha_seq_if.sv
button_debounce.sv
startup_sequencer.sv
alpha_control.sv
alpha_readout.sv
alpha_subsystem.sv
alpha_props.sv
alpha_tb.sv

// ==== button_debounce.sv ====
`include "alpha_defines.svh"
`timescale 1ns/1ns
`default_nettype none

module button_debounce (
	input  logic sysclk,
	input  logic reset,
	input  logic button,
	output logic press
);

	// button idles high
	logic [1:0] sync_ff;
	logic debounced;
	logic [5:0] stable_cnt;

	always_ff @(posedge sysclk) begin
		press <= 1'b0;
		if (reset) begin
			sync_ff <= 2'b11;
			debounced <= 1'b1;
			stable_cnt <= '0;
		end else begin
			sync_ff <= {sync_ff[0], button};
			if (sync_ff[1] == debounced) begin
				// any bounce back restarts the count
				stable_cnt <= '0;
			end else if (stable_cnt == `ALPHA_DEBOUNCE_CYCLES - 1) begin
				stable_cnt <= '0;
				debounced <= sync_ff[1];
				// pulse on the move to pressed only
				press <= !sync_ff[1];
			end else begin
				stable_cnt <= stable_cnt + 6'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== startup_sequencer.sv ====
`include "alpha_defines.svh"
`timescale 1ns/1ns
`default_nettype none

module startup_sequencer (
	input  logic sysclk,
	input  logic reset,
	input  logic press,
	alpha_seq_if.sequencer seq,
	output logic [3:0] step_done
);

	alpha_pkg::seq_state_t state;
	logic [6:0] wait_cnt;
	logic wait_over;

	// counter only runs while the control block is free
	assign wait_over = !seq.ctrl_busy && (wait_cnt == `ALPHA_SEQ_WAIT_CYCLES - 1);

	always_ff @(posedge sysclk) begin
		seq.do_dreset <= 1'b0;
		seq.do_sync <= 1'b0;
		seq.do_load <= 1'b0;
		seq.do_readout <= 1'b0;
		if (reset) begin
			state <= alpha_pkg::WAIT_DRESET;
			wait_cnt <= '0;
			step_done <= '0;
		end else begin
			case (state)
				alpha_pkg::WAIT_DRESET,
				alpha_pkg::WAIT_SYNC,
				alpha_pkg::WAIT_LOAD: begin
					if (wait_over) begin
						wait_cnt <= '0;
					end else if (!seq.ctrl_busy) begin
						wait_cnt <= wait_cnt + 7'd1;
					end
				end
				default: begin
					wait_cnt <= '0;
				end
			endcase

			// --------------------
			// timed steps
			case (state)
				alpha_pkg::WAIT_DRESET: begin
					if (wait_over) begin
						seq.do_dreset <= 1'b1;
						step_done[0] <= 1'b1;
						state <= alpha_pkg::WAIT_SYNC;
					end
				end
				alpha_pkg::WAIT_SYNC: begin
					if (wait_over) begin
						seq.do_sync <= 1'b1;
						step_done[1] <= 1'b1;
						state <= alpha_pkg::WAIT_LOAD;
					end
				end
				alpha_pkg::WAIT_LOAD: begin
					if (wait_over) begin
						seq.do_load <= 1'b1;
						step_done[2] <= 1'b1;
						state <= alpha_pkg::ARMED;
					end
				end
				alpha_pkg::ARMED: begin
					// presses during a busy cycle are lost
					if (press && !seq.ctrl_busy) begin
						seq.do_readout <= 1'b1;
						step_done[3] <= 1'b1;
					end
				end
				default: begin
					state <= alpha_pkg::WAIT_DRESET;
				end
			endcase
		end
	end

endmodule

`default_nettype wire
